//--- filelist.f
tnoc_pkg.sv
tnoc_flit_connector.sv
tnoc_vc_fifo.sv
tnoc_vc_arbiter.sv
tnoc_credit_counter.sv
tnoc_flit_link.sv
tb_tnoc_flit_link.sv

//--- tb_tnoc_flit_link.sv
`timescale 1ns/1ns
`default_nettype none

module tb_tnoc_flit_link;

  localparam int CH       = tnoc_pkg::CHANNELS;
  localparam int NUM_PKTS = 14;

  // ----------------------------------------------------------------------
  // packet table: channel, length, external type code, data base
  // ----------------------------------------------------------------------
  localparam int          PKT_VC   [NUM_PKTS] = '{0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1};
  localparam int          PKT_LEN  [NUM_PKTS] = '{3, 1, 1, 4, 4, 2, 2, 3, 1, 1, 3, 2, 1, 1};
  localparam logic [1:0]  PKT_EXT  [NUM_PKTS] = '{2'b01, 2'b10, 2'b10, 2'b01, 2'b01, 2'b10,
                                                   2'b10, 2'b01, 2'b01, 2'b10, 2'b10, 2'b01,
                                                   2'b01, 2'b10};
  localparam logic [31:0] PKT_BASE [NUM_PKTS] = '{'h100, 'h200, 'h110, 'h210, 'h120, 'h220,
                                                   'h130, 'h230, 'h140, 'h240, 'h150, 'h250,
                                                   'h160, 'h260};

  logic                                 clk;
  logic                                 rst_n;
  logic [CH-1:0]                        in_valid;
  tnoc_pkg::tnoc_ext_flit_type [CH-1:0] in_type;
  logic [CH-1:0]                        in_head;
  logic [CH-1:0]                        in_tail;
  logic [CH-1:0][31:0]                  in_data;
  logic [CH-1:0]                        credit_return;
  logic [CH-1:0]                        in_ready;
  logic                                 out_valid;
  logic [tnoc_pkg::VC_WIDTH-1:0]        out_vc;
  tnoc_pkg::tnoc_flit_type              out_type;
  logic                                 out_head;
  logic                                 out_tail;
  logic [31:0]                          out_data;

  logic [35:0] in_q  [CH][$];  // ext code, head, tail, data
  logic [34:0] exp_q [CH][$];  // internal type, head, tail, data
  int          ret_q [CH][$];  // cycle at which a credit goes back
  int          acc [CH];
  int          sent [CH];
  int          tally [CH];     // credits the receiver model has handed out
  logic [CH-1:0] pending;
  logic [CH-1:0] seen_full;
  logic        withhold;
  logic        locked;
  int          lock_vc;
  int          rr;
  int          hold_cnt;
  int          cycles;
  int          flits_out;
  int          total_flits;
  int          errors;
  logic [31:0] rng;

  tnoc_flit_link u_tnoc_flit_link (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
    errors++;
    $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
  endtask

  task automatic load_packets();
    logic [1:0]              ext;
    logic                    hd;
    logic                    tl;
    logic [31:0]             d;
    tnoc_pkg::tnoc_flit_type t;
    for (int p = 0; p < NUM_PKTS; p++) begin
      ext = PKT_EXT[p];
      t = (ext == tnoc_pkg::EXT_RESPONSE) ? tnoc_pkg::FLIT_TYPE_RESPONSE
                                          : tnoc_pkg::FLIT_TYPE_REQUEST;
      for (int f = 0; f < PKT_LEN[p]; f++) begin
        hd = (f == 0);
        tl = (f == PKT_LEN[p] - 1);
        d  = PKT_BASE[p] + f;
        in_q[PKT_VC[p]].push_back({ext, hd, tl, d});
        exp_q[PKT_VC[p]].push_back({t, hd, tl, d});
        total_flits++;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // per-cycle checks, all sampled mid-cycle
  // ----------------------------------------------------------------------
  task automatic check_inputs();
    logic exp_rdy;
    for (int i = 0; i < CH; i++) begin
      if (pending[i]) begin  // taken on the last rising edge
        void'(in_q[i].pop_front());
        acc[i]++;
      end
      exp_rdy = (acc[i] - sent[i]) < tnoc_pkg::FIFO_DEPTH;
      if (in_ready[i] !== exp_rdy) report_mismatch($sformatf("in_ready[%0d]", i), exp_rdy, in_ready[i]);
      if (withhold && !in_ready[i]) seen_full[i] = 1'b1;
    end
  endtask

  task automatic check_output();
    logic [CH-1:0] avail;
    logic [CH-1:0] start;
    logic          exp_valid;
    int            exp_vc;
    int            vc;
    logic [34:0]   e;
    exp_valid = 1'b0;
    exp_vc    = 0;
    for (int i = 0; i < CH; i++) begin
      avail[i] = (acc[i] > sent[i]) && (tally[i] > 0) && (exp_q[i].size() > 0);
      start[i] = avail[i] && exp_q[i][0][33];
    end
    if (locked) begin
      exp_valid = avail[lock_vc];
      exp_vc    = lock_vc;
    end else begin
      for (int k = CH - 1; k >= 0; k--) begin  // lowest offset from rr wins
        if (start[(rr + k) % CH]) begin
          exp_valid = 1'b1;
          exp_vc    = (rr + k) % CH;
        end
      end
    end
    if (out_valid !== exp_valid) report_mismatch("out_valid", exp_valid, out_valid);
    if (out_valid !== 1'b1) return;
    vc = int'(out_vc);
    if (exp_valid && vc != exp_vc) report_mismatch("out_vc", exp_vc, vc);
    if (exp_q[vc].size() == 0) begin
      errors++;
      $display("flit on vc %0d at %0t ns with none left to send", vc, $time);
      return;
    end
    e = exp_q[vc].pop_front();
    if (out_data !== e[31:0]) report_mismatch("out_data", e[31:0], out_data);
    if (out_tail !== e[32]) report_mismatch("out_tail", e[32], out_tail);
    if (out_head !== e[33]) report_mismatch("out_head", e[33], out_head);
    if (out_type !== tnoc_pkg::tnoc_flit_type'(e[34])) report_mismatch("out_type", e[34], out_type);
    if (tally[vc] <= 0) begin
      errors++;
      $display("flit sent on vc %0d at %0t ns with no credit left", vc, $time);
    end
    tally[vc]--;
    sent[vc]++;
    flits_out++;
    rng = lcg_next(rng);
    ret_q[vc].push_back(cycles + 1 + int'(rng[17:16]));
    locked  = !out_tail;
    lock_vc = vc;
    if (out_tail) rr = (vc + 1) % CH;
  endtask

  task automatic drive_credits();
    credit_return = '0;
    if (withhold && (&seen_full)) begin
      hold_cnt++;
      withhold = (hold_cnt < 6);  // both fifos sit full a few cycles
    end
    if (withhold) return;
    for (int i = 0; i < CH; i++) begin
      if (ret_q[i].size() > 0 && ret_q[i][0] <= cycles) begin
        void'(ret_q[i].pop_front());
        credit_return[i] = 1'b1;
        tally[i]++;
      end
    end
  endtask

  task automatic drive_inputs();
    for (int i = 0; i < CH; i++) begin
      in_valid[i] = (in_q[i].size() > 0);
      pending[i]  = in_valid[i] && in_ready[i];
      if (in_valid[i]) begin
        in_type[i] = tnoc_pkg::tnoc_ext_flit_type'(in_q[i][0][35:34]);
        in_head[i] = in_q[i][0][33];
        in_tail[i] = in_q[i][0][32];
        in_data[i] = in_q[i][0][31:0];
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      cycles++;
      check_inputs();
      check_output();
      drive_credits();
      drive_inputs();
    end
  end

  // ----------------------------------------------------------------------
  // run control
  // ----------------------------------------------------------------------
  initial begin
    int limit;
    rst_n = 1'b0;
    in_valid = '0;
    in_type = {CH{tnoc_pkg::EXT_REQUEST}};
    in_head = '0;
    in_tail = '0;
    in_data = '0;
    credit_return = '0;
    pending = '0;
    seen_full = '0;
    withhold = 1'b1;  // no credits back until both fifos fill
    locked = 1'b0;
    lock_vc = 0;
    rr = 0;
    hold_cnt = 0;
    cycles = 0;
    flits_out = 0;
    total_flits = 0;
    errors = 0;
    rng = 32'h3494;
    for (int i = 0; i < CH; i++) begin
      acc[i] = 0;
      sent[i] = 0;
      tally[i] = tnoc_pkg::CREDITS;
    end
    load_packets();
    limit = 20 * total_flits + 200;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
    while (flits_out < total_flits && cycles < limit) @(posedge clk);
    if (flits_out < total_flits) begin
      errors++;
      $display("timeout after %0d cycles, %0d of %0d flits came out", cycles, flits_out,
               total_flits);
    end
    for (int i = 0; i < CH; i++) begin
      if (!seen_full[i]) begin
        errors++;
        $display("in_ready on vc %0d never dropped while credits were held back", i);
      end
    end
    $display("errors: %0d, flits out: %0d of %0d", errors, flits_out, total_flits);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tnoc_flit_link.sv
`timescale 1ns/1ns
`default_nettype none

module tnoc_flit_link (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  input  logic [tnoc_pkg::CHANNELS-1:0]                           in_valid,
  input  tnoc_pkg::tnoc_ext_flit_type [tnoc_pkg::CHANNELS-1:0]    in_type,
  input  logic [tnoc_pkg::CHANNELS-1:0]                           in_head,
  input  logic [tnoc_pkg::CHANNELS-1:0]                           in_tail,
  input  logic [tnoc_pkg::CHANNELS-1:0][tnoc_pkg::DATA_WIDTH-1:0] in_data,
  input  logic [tnoc_pkg::CHANNELS-1:0]                           credit_return,
  output logic [tnoc_pkg::CHANNELS-1:0]                           in_ready,
  output logic                                                    out_valid,
  output logic [tnoc_pkg::VC_WIDTH-1:0]                           out_vc,
  output tnoc_pkg::tnoc_flit_type                                 out_type,
  output logic                                                    out_head,
  output logic                                                    out_tail,
  output logic [tnoc_pkg::DATA_WIDTH-1:0]                         out_data
);

  logic [tnoc_pkg::CHANNELS-1:0]                           push;
  tnoc_pkg::tnoc_flit_type [tnoc_pkg::CHANNELS-1:0]        push_type;
  logic [tnoc_pkg::CHANNELS-1:0]                           push_head;
  logic [tnoc_pkg::CHANNELS-1:0]                           push_tail;
  logic [tnoc_pkg::CHANNELS-1:0][tnoc_pkg::DATA_WIDTH-1:0] push_data;

  logic [tnoc_pkg::CHANNELS-1:0]                           fifo_full;
  logic [tnoc_pkg::CHANNELS-1:0]                           fifo_empty;
  logic [tnoc_pkg::CHANNELS-1:0]                           pop;
  tnoc_pkg::tnoc_flit_type [tnoc_pkg::CHANNELS-1:0]        head_type;
  logic [tnoc_pkg::CHANNELS-1:0]                           head_head;
  logic [tnoc_pkg::CHANNELS-1:0]                           head_tail;
  logic [tnoc_pkg::CHANNELS-1:0][tnoc_pkg::DATA_WIDTH-1:0] head_data;

  logic [tnoc_pkg::CHANNELS-1:0] can_send;
  logic [tnoc_pkg::VC_WIDTH-1:0] grant_vc;

  // ----------------------------------------------------------------------
  // input side
  // ----------------------------------------------------------------------
  tnoc_flit_connector u_connector (
    .clk(clk), .rst_n(rst_n),
    .ext_valid(in_valid), .ext_type(in_type), .ext_head(in_head),
    .ext_tail(in_tail), .ext_data(in_data), .fifo_full(fifo_full),
    .ext_ready(in_ready), .push(push), .push_type(push_type),
    .push_head(push_head), .push_tail(push_tail), .push_data(push_data)
  );

  for (genvar i = 0; i < tnoc_pkg::CHANNELS; i++) begin : g_fifo
    tnoc_vc_fifo u_fifo (
      .clk(clk), .rst_n(rst_n),
      .push(push[i]), .push_type(push_type[i]), .push_head(push_head[i]),
      .push_tail(push_tail[i]), .push_data(push_data[i]), .pop(pop[i]),
      .full(fifo_full[i]), .empty(fifo_empty[i]), .head_type(head_type[i]),
      .head_head(head_head[i]), .head_tail(head_tail[i]), .head_data(head_data[i])
    );
  end

  // ----------------------------------------------------------------------
  // output side
  // ----------------------------------------------------------------------
  tnoc_vc_arbiter u_arbiter (
    .clk(clk), .rst_n(rst_n),
    .empty(fifo_empty), .head_is_head(head_head), .head_is_tail(head_tail),
    .can_send(can_send), .pop(pop), .grant_vc(grant_vc), .out_valid(out_valid)
  );

  tnoc_credit_counter u_credit (
    .clk(clk), .rst_n(rst_n),
    .send(out_valid), .send_vc(grant_vc),   // every sent flit costs one credit
    .credit_return(credit_return), .can_send(can_send)
  );

  assign out_vc   = grant_vc;
  assign out_type = head_type[grant_vc];
  assign out_head = head_head[grant_vc];
  assign out_tail = head_tail[grant_vc];
  assign out_data = head_data[grant_vc];  // granted fifo head

endmodule

`default_nettype wire

//--- tnoc_credit_counter.sv
`timescale 1ns/1ns
`default_nettype none

module tnoc_credit_counter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          send,
  input  logic [tnoc_pkg::VC_WIDTH-1:0] send_vc,
  input  logic [tnoc_pkg::CHANNELS-1:0] credit_return,
  output logic [tnoc_pkg::CHANNELS-1:0] can_send
);

  logic [tnoc_pkg::CHANNELS-1:0][tnoc_pkg::CREDIT_WIDTH-1:0] count;

  for (genvar i = 0; i < tnoc_pkg::CHANNELS; i++) begin : g_vc
    logic send_here;

    assign send_here = send && (int'(send_vc) == i);

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        count[i] <= tnoc_pkg::CREDIT_WIDTH'(tnoc_pkg::CREDITS);
      end else begin
        case ({send_here, credit_return[i]})
          2'b10:   count[i] <= count[i] - 1'b1;
          2'b01:   count[i] <= count[i] + 1'b1;
          default: count[i] <= count[i];  // both cancel out
        endcase
      end
    end

    assign can_send[i] = (count[i] != '0);

    // receiver returns no more than it was given
    a_no_excess_return: assert property (
      @(posedge clk) disable iff (!rst_n)
      (credit_return[i] && !send_here) |-> (count[i] < tnoc_pkg::CREDITS)
    );

    // a flit only leaves while its vc holds credit
    a_send_with_credit: assert property (
      @(posedge clk) disable iff (!rst_n) send_here |-> (count[i] != '0)
    );
  end

endmodule

`default_nettype wire

//--- tnoc_vc_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module tnoc_vc_arbiter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [tnoc_pkg::CHANNELS-1:0] empty,
  input  logic [tnoc_pkg::CHANNELS-1:0] head_is_head,
  input  logic [tnoc_pkg::CHANNELS-1:0] head_is_tail,
  input  logic [tnoc_pkg::CHANNELS-1:0] can_send,
  output logic [tnoc_pkg::CHANNELS-1:0] pop,
  output logic [tnoc_pkg::VC_WIDTH-1:0] grant_vc,
  output logic                          out_valid
);

  tnoc_pkg::tnoc_arb_state        state;
  logic [tnoc_pkg::VC_WIDTH-1:0]  locked_vc;
  logic [tnoc_pkg::VC_WIDTH-1:0]  rr_ptr;    // first vc to look at when idle

  logic [tnoc_pkg::CHANNELS-1:0]  send_ready;
  logic [tnoc_pkg::CHANNELS-1:0]  start_ready;
  logic                           pick_found;
  logic [tnoc_pkg::VC_WIDTH-1:0]  pick_vc;
  logic [tnoc_pkg::VC_WIDTH-1:0]  next_vc;

  assign send_ready  = ~empty & can_send;
  assign start_ready = send_ready & head_is_head;  // only packet starts when idle

  // ----------------------------------------------------------------------
  // round-robin pick
  // ----------------------------------------------------------------------
  always_comb begin
    pick_found = 1'b0;
    pick_vc    = rr_ptr;
    for (int k = 0; k < tnoc_pkg::CHANNELS; k++) begin
      if (!pick_found && start_ready[(int'(rr_ptr) + k) % tnoc_pkg::CHANNELS]) begin
        pick_found = 1'b1;
        pick_vc    = tnoc_pkg::VC_WIDTH'((int'(rr_ptr) + k) % tnoc_pkg::CHANNELS);
      end
    end
  end

  assign grant_vc  = (state == tnoc_pkg::ARB_LOCKED) ? locked_vc : pick_vc;
  assign out_valid = (state == tnoc_pkg::ARB_LOCKED) ? send_ready[locked_vc] : pick_found;

  always_comb begin
    pop           = '0;
    pop[grant_vc] = out_valid;
  end

  assign next_vc = (int'(grant_vc) == tnoc_pkg::CHANNELS - 1) ? '0 : grant_vc + 1'b1;

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= tnoc_pkg::ARB_IDLE;
      locked_vc <= '0;
      rr_ptr    <= '0;
    end else if (out_valid) begin
      if (head_is_tail[grant_vc]) begin
        state  <= tnoc_pkg::ARB_IDLE;
        rr_ptr <= next_vc;                  // served vc goes last
      end else begin
        state     <= tnoc_pkg::ARB_LOCKED;
        locked_vc <= grant_vc;
      end
    end
  end

  // a new packet must not start inside a locked one
  a_no_head_while_locked: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == tnoc_pkg::ARB_LOCKED && out_valid) |-> !head_is_head[grant_vc]
  );

endmodule

`default_nettype wire

//--- tnoc_vc_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module tnoc_vc_fifo (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            push,
  input  tnoc_pkg::tnoc_flit_type         push_type,
  input  logic                            push_head,
  input  logic                            push_tail,
  input  logic [tnoc_pkg::DATA_WIDTH-1:0] push_data,
  input  logic                            pop,
  output logic                            full,
  output logic                            empty,
  output tnoc_pkg::tnoc_flit_type         head_type,
  output logic                            head_head,
  output logic                            head_tail,
  output logic [tnoc_pkg::DATA_WIDTH-1:0] head_data
);

  tnoc_pkg::tnoc_flit_type         type_mem [tnoc_pkg::FIFO_DEPTH];
  logic                            head_mem [tnoc_pkg::FIFO_DEPTH];
  logic                            tail_mem [tnoc_pkg::FIFO_DEPTH];
  logic [tnoc_pkg::DATA_WIDTH-1:0] data_mem [tnoc_pkg::FIFO_DEPTH];

  logic [tnoc_pkg::PTR_WIDTH-1:0]   wr_ptr;
  logic [tnoc_pkg::PTR_WIDTH-1:0]   rd_ptr;
  logic [tnoc_pkg::COUNT_WIDTH-1:0] count;

  function automatic logic [tnoc_pkg::PTR_WIDTH-1:0] next_ptr(
    logic [tnoc_pkg::PTR_WIDTH-1:0] ptr
  );
    if (int'(ptr) == tnoc_pkg::FIFO_DEPTH - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (push) begin
      type_mem[wr_ptr] <= push_type;
      head_mem[wr_ptr] <= push_head;
      tail_mem[wr_ptr] <= push_tail;
      data_mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or push and pop together
      endcase
    end
  end

  assign full  = (count == tnoc_pkg::FIFO_DEPTH);
  assign empty = (count == 0);

  assign head_type = type_mem[rd_ptr];
  assign head_head = head_mem[rd_ptr];
  assign head_tail = tail_mem[rd_ptr];
  assign head_data = data_mem[rd_ptr];

  a_no_overflow:  assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

//--- tnoc_flit_connector.sv
`timescale 1ns/1ns
`default_nettype none

module tnoc_flit_connector (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic [tnoc_pkg::CHANNELS-1:0]                          ext_valid,
  input  tnoc_pkg::tnoc_ext_flit_type [tnoc_pkg::CHANNELS-1:0]   ext_type,
  input  logic [tnoc_pkg::CHANNELS-1:0]                          ext_head,
  input  logic [tnoc_pkg::CHANNELS-1:0]                          ext_tail,
  input  logic [tnoc_pkg::CHANNELS-1:0][tnoc_pkg::DATA_WIDTH-1:0] ext_data,
  input  logic [tnoc_pkg::CHANNELS-1:0]                          fifo_full,
  output logic [tnoc_pkg::CHANNELS-1:0]                          ext_ready,
  output logic [tnoc_pkg::CHANNELS-1:0]                          push,
  output tnoc_pkg::tnoc_flit_type [tnoc_pkg::CHANNELS-1:0]       push_type,
  output logic [tnoc_pkg::CHANNELS-1:0]                          push_head,
  output logic [tnoc_pkg::CHANNELS-1:0]                          push_tail,
  output logic [tnoc_pkg::CHANNELS-1:0][tnoc_pkg::DATA_WIDTH-1:0] push_data
);

  function automatic tnoc_pkg::tnoc_flit_type convert_flit_type(
    tnoc_pkg::tnoc_ext_flit_type ext
  );
    case (ext)
      tnoc_pkg::EXT_RESPONSE: return tnoc_pkg::FLIT_TYPE_RESPONSE;
      default:                return tnoc_pkg::FLIT_TYPE_REQUEST;
    endcase
  endfunction

  for (genvar i = 0; i < tnoc_pkg::CHANNELS; i++) begin : g_vc
    assign ext_ready[i] = !fifo_full[i];
    assign push[i]      = ext_valid[i] && !fifo_full[i];  // accepted flit

    assign push_type[i] = convert_flit_type(ext_type[i]);
    assign push_head[i] = ext_head[i];
    assign push_tail[i] = ext_tail[i];
    assign push_data[i] = ext_data[i];

    // sender must never offer an undefined type code
    a_legal_type: assert property (
      @(posedge clk) disable iff (!rst_n)
      ext_valid[i] |-> ext_type[i] inside {tnoc_pkg::EXT_REQUEST, tnoc_pkg::EXT_RESPONSE}
    );
  end

endmodule

`default_nettype wire

//--- tnoc_pkg.sv
`default_nettype none

package tnoc_pkg;

  // ----------------------------------------------------------------------
  // sizes
  // ----------------------------------------------------------------------
  localparam int CHANNELS     = 2;
  localparam int VC_WIDTH     = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;
  localparam int DATA_WIDTH   = 32;

  localparam int FIFO_DEPTH   = 4;
  localparam int PTR_WIDTH    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int COUNT_WIDTH  = $clog2(FIFO_DEPTH + 1);

  localparam int CREDITS      = 4;  // downstream slots per vc
  localparam int CREDIT_WIDTH = $clog2(CREDITS + 1);

  // ----------------------------------------------------------------------
  // flit encodings
  // ----------------------------------------------------------------------
  // internal format
  typedef enum logic {
    FLIT_TYPE_REQUEST  = 1'b0,
    FLIT_TYPE_RESPONSE = 1'b1
  } tnoc_flit_type;

  // external format, 2'b00 and 2'b11 not allowed
  typedef enum logic [1:0] {
    EXT_REQUEST  = 2'b01,
    EXT_RESPONSE = 2'b10
  } tnoc_ext_flit_type;

  // ----------------------------------------------------------------------
  // arbiter
  // ----------------------------------------------------------------------
  typedef enum logic {
    ARB_IDLE,
    ARB_LOCKED   // output held by one vc until its tail
  } tnoc_arb_state;

endpackage

`default_nettype wire
